/* project.f */
+incdir+rtl
rtl/sie_pkg.sv
rtl/usb_crc16.sv
rtl/usb_packet_rx.sv
rtl/usb_out_fifo.sv
rtl/usb_handshake_tx.sv
rtl/sie_rx_top.sv
dv/tb_sie_rx.sv

/* Bender.yml */
package:
  name: sie_rx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sie_pkg.sv
      - rtl/usb_crc16.sv
      - rtl/usb_packet_rx.sv
      - rtl/usb_out_fifo.sv
      - rtl/usb_handshake_tx.sv
      - rtl/sie_rx_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_sie_rx.sv

/* dv/tb_sie_rx.sv */
/*
 * Testbench for the USB receive engine
 *  - Clock, reset and byte level packet builders with CRC5/CRC16
 *  - SOF, SETUP, OUT and DATA stimulus with random payloads
 *  - Scoreboard of expected endpoint bytes and handshake checks
 *  - Concurrent checks on output hold and commit latency
 */
`timescale 1ns/10ps
`default_nettype none
`include "sie_settings.svh"

module tb_sie_rx;

   localparam logic [6:0] DEV_ADDR = 7'h2A;
   // PID codes from the USB specification
   localparam logic [3:0] PID_OUT   = 4'h1;
   localparam logic [3:0] PID_SOF   = 4'h5;
   localparam logic [3:0] PID_SETUP = 4'hD;
   localparam logic [3:0] PID_DATA0 = 4'h3;
   localparam logic [3:0] PID_DATA1 = 4'hB;
   localparam logic [7:0] HS_ACK    = 8'hD2;
   localparam logic [7:0] HS_NAK    = 8'h5A;
   localparam logic [7:0] HS_STALL  = 8'h1E;

   // Two cycles per byte plus framing, and the longest wait after each packet
   localparam int NUM_PKTS   = 22;
   localparam int PKT_CYCLES = 2 * (`SIE_MAX_PACKET + 3) + 3;
   localparam int LIMIT      = NUM_PKTS * (PKT_CYCLES + 4 * `SIE_TURNAROUND) + 64;

   logic        clk_i = 1'b0;
   logic        rstn;
   logic [7:0]  rx_data_i;
   logic        rx_byte_valid_i;
   logic        rx_active_i;
   logic        rx_err_i;
   logic [6:0]  addr_i;
   logic        stall_i;
   logic        out_nak_i;
   logic        out_ready_i;
   logic        tx_ready_i;
   logic [7:0]  out_data_o;
   logic        out_valid_o;
   logic [7:0]  tx_data_o;
   logic        tx_valid_o;
   logic [10:0] frame_o;
   logic [3:0]  endp_o;
   logic        setup_o;

   integer      seed = 32'h18200cd9;
   int          cyc = 0;
   int          errors = 0;
   int          test_base;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic [7:0]  pkt[$];
   logic [7:0]  payload[$];
   logic [7:0]  exp_q[$];
   logic [10:0] frame_a;

   sie_rx_top i_sie_rx_top (
      .clk_i           (clk_i),
      .rstn            (rstn),
      .rx_data_i       (rx_data_i),
      .rx_byte_valid_i (rx_byte_valid_i),
      .rx_active_i     (rx_active_i),
      .rx_err_i        (rx_err_i),
      .addr_i          (addr_i),
      .stall_i         (stall_i),
      .out_nak_i       (out_nak_i),
      .out_ready_i     (out_ready_i),
      .tx_ready_i      (tx_ready_i),
      .out_data_o      (out_data_o),
      .out_valid_o     (out_valid_o),
      .tx_data_o       (tx_data_o),
      .tx_valid_o      (tx_valid_o),
      .frame_o         (frame_o),
      .endp_o          (endp_o),
      .setup_o         (setup_o)
   );

   always #50 clk_i = ~clk_i;

   function automatic void mismatch(input string name, input logic [31:0] exp,
                                    input logic [31:0] got);
      errors = errors + 1;
      $display("CHECK FAILED %s: expected 0x%0h got 0x%0h", name, exp, got);
   endfunction

   function automatic void problem(input string msg);
      errors = errors + 1;
      $display("ERROR at cycle %0d: %s", cyc, msg);
   endfunction

   // Token CRC5, x^5+x^2+1, sent inverted with the high register bit first
   function automatic logic [4:0] crc5_field(input logic [10:0] d);
      logic [4:0] r;
      logic [4:0] f;
      logic       fb;
      r = 5'h1F;
      for (int i = 0; i < 11; i++) begin
         fb = d[i] ^ r[4];
         r  = {r[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
      end
      for (int j = 0; j < 5; j++) begin
         f[j] = ~r[4 - j];
      end
      return f;
   endfunction

   // Data CRC16, x^16+x^15+x^2+1, one byte LSB first
   function automatic logic [15:0] crc16_step(input logic [15:0] r_in, input logic [7:0] b);
      logic [15:0] r;
      logic        fb;
      r = r_in;
      for (int i = 0; i < 8; i++) begin
         fb = b[i] ^ r[15];
         r  = {r[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
      return r;
   endfunction

   task automatic start_test();
      test_base = errors;
      tests_run = tests_run + 1;
   endtask

   task automatic finish_test(input string name);
      if (errors != test_base) begin
         tests_failed = tests_failed + 1;
         $display("Test %0d %s: FAIL", tests_run, name);
      end else begin
         $display("Test %0d %s: PASS", tests_run, name);
      end
   endtask

   // Ends on the edge where rx_active_i is dropped
   task automatic send_packet();
      @(posedge clk_i);
      rx_active_i <= 1'b1;
      foreach (pkt[i]) begin
         @(posedge clk_i);
         rx_data_i       <= pkt[i];
         rx_byte_valid_i <= 1'b1;
         @(posedge clk_i);
         rx_byte_valid_i <= 1'b0;
      end
      @(posedge clk_i);
      rx_active_i <= 1'b0;
   endtask

   // Returns one cycle after the end of packet, when token outputs have settled
   task automatic send_token(input logic [3:0] pid, input logic [10:0] tok, input logic bad_crc);
      logic [4:0] crc;
      crc = crc5_field(tok) ^ {4'b0, bad_crc};
      pkt.delete();
      pkt.push_back({~pid, pid});
      pkt.push_back(tok[7:0]);
      pkt.push_back({crc, tok[10:8]});
      send_packet();
      @(posedge clk_i);
      @(negedge clk_i);
   endtask

   task automatic make_payload(input int n);
      payload.delete();
      repeat (n) begin
         payload.push_back(8'($random(seed)));
      end
   endtask

   task automatic send_data(input logic [3:0] pid, input logic bad_crc, input logic deliver);
      logic [15:0] r;
      logic [15:0] f;
      r = 16'hFFFF;
      pkt.delete();
      pkt.push_back({~pid, pid});
      foreach (payload[i]) begin
         r = crc16_step(r, payload[i]);
         pkt.push_back(payload[i]);
         if (deliver) begin
            exp_q.push_back(payload[i]);
         end
      end
      for (int j = 0; j < 16; j++) begin
         f[j] = ~r[15 - j];
      end
      if (bad_crc) begin
         f = f ^ 16'h0040;
      end
      pkt.push_back(f[7:0]);
      pkt.push_back(f[15:8]);
      send_packet();
   endtask

   // Counts edges from the end of packet until tx_valid_o is seen, then accepts the byte late
   task automatic check_handshake(input logic [7:0] exp_byte);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < 4 * `SIE_TURNAROUND) begin
         @(posedge clk_i);
         n = n + 1;
         @(negedge clk_i);
         seen = tx_valid_o;
      end
      if (!seen) begin
         problem("no handshake byte appeared after the data packet");
      end else begin
         assert (n == `SIE_TURNAROUND) else mismatch("tx_valid_o delay", `SIE_TURNAROUND, n);
         assert (tx_data_o == exp_byte) else mismatch("tx_data_o", exp_byte, tx_data_o);
         repeat (2) @(posedge clk_i);
         tx_ready_i <= 1'b1;
         @(posedge clk_i);
         tx_ready_i <= 1'b0;
      end
   endtask

   task automatic expect_silence(input int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         assert (!tx_valid_o) else problem("handshake byte sent for a packet that needs none");
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 8 * `SIE_FIFO_DEPTH) begin
         @(negedge clk_i);
         n = n + 1;
      end
      assert (exp_q.size() == 0) else begin
         problem("payload bytes did not reach the endpoint port");
         exp_q.delete();
      end
   endtask

   // Scoreboard at the endpoint port
   always @(posedge clk_i) begin
      if (rstn && out_valid_o && out_ready_i) begin
         if (exp_q.size() == 0) begin
            problem("endpoint port delivered a byte that was not expected");
         end else begin
            assert (out_data_o == exp_q[0]) else mismatch("out_data_o", exp_q[0], out_data_o);
            void'(exp_q.pop_front());
         end
      end
   end

   always @(posedge clk_i) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("Timeout after %0d cycles, the run did not complete", LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   out_hold: assert property (@(posedge clk_i) disable iff (!rstn)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else problem("endpoint byte changed or dropped while out_ready_i was low");

   tx_hold: assert property (@(posedge clk_i) disable iff (!rstn)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
      else problem("handshake byte changed or dropped while tx_ready_i was low");

   commit_latency: assert property (@(posedge clk_i) disable iff (!rstn)
      i_sie_rx_top.commit |-> ##[1:2] out_valid_o)
      else problem("committed bytes were not presented at the endpoint port in time");

   initial begin
      rstn            = 1'b0;
      rx_data_i       = 8'h00;
      rx_byte_valid_i = 1'b0;
      rx_active_i     = 1'b0;
      rx_err_i        = 1'b0;
      addr_i          = DEV_ADDR;
      stall_i         = 1'b0;
      out_nak_i       = 1'b0;
      out_ready_i     = 1'b1;
      tx_ready_i      = 1'b0;
      repeat (4) @(posedge clk_i);
      rstn <= 1'b1;
      @(negedge clk_i);

      start_test();
      assert (!tx_valid_o) else mismatch("tx_valid_o", 0, tx_valid_o);
      assert (!out_valid_o) else mismatch("out_valid_o", 0, out_valid_o);
      assert (!setup_o) else mismatch("setup_o", 0, setup_o);
      assert (frame_o == 11'd0) else mismatch("frame_o", 0, frame_o);
      assert (endp_o == 4'd0) else mismatch("endp_o", 0, endp_o);
      finish_test("reset values");

      start_test();
      frame_a = 11'($random(seed));
      send_token(PID_SOF, frame_a, 1'b0);
      assert (frame_o == frame_a) else mismatch("frame_o", frame_a, frame_o);
      send_token(PID_SOF, frame_a ^ 11'h155, 1'b1);
      assert (frame_o == frame_a) else mismatch("frame_o", frame_a, frame_o);
      finish_test("SOF frame number and CRC5");

      start_test();
      send_token(PID_SETUP, {`SIE_ENDP_CTRL, DEV_ADDR}, 1'b0);
      assert (setup_o) else mismatch("setup_o", 1, setup_o);
      assert (endp_o == `SIE_ENDP_CTRL) else mismatch("endp_o", `SIE_ENDP_CTRL, endp_o);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA0, 1'b0, 1'b1);
      check_handshake(HS_ACK);
      wait_drain();
      finish_test("SETUP with DATA0 and ACK");

      start_test();
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      assert (!setup_o) else mismatch("setup_o", 0, setup_o);
      assert (endp_o == `SIE_ENDP_BULK) else mismatch("endp_o", `SIE_ENDP_BULK, endp_o);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA0, 1'b1, 1'b0);
      expect_silence(3 * `SIE_TURNAROUND);
      send_token(PID_OUT, {4'd2, DEV_ADDR + 7'd1}, 1'b0);
      assert (endp_o == `SIE_ENDP_BULK) else mismatch("endp_o", `SIE_ENDP_BULK, endp_o);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA0, 1'b0, 1'b0);
      expect_silence(3 * `SIE_TURNAROUND);
      wait_drain();
      finish_test("bad CRC16 and foreign address");

      start_test();
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA0, 1'b0, 1'b1);
      check_handshake(HS_ACK);
      wait_drain();
      // Same toggle again, ACKed but dropped
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(PID_DATA0, 1'b0, 1'b0);
      check_handshake(HS_ACK);
      wait_drain();
      finish_test("repeated DATA0 on bulk endpoint");

      start_test();
      @(posedge clk_i);
      stall_i <= 1'b1;
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA1, 1'b0, 1'b0);
      check_handshake(HS_STALL);
      stall_i   <= 1'b0;
      out_nak_i <= 1'b1;
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      send_data(PID_DATA1, 1'b0, 1'b0);
      check_handshake(HS_NAK);
      out_nak_i   <= 1'b0;
      out_ready_i <= 1'b0;
      // Two packets use up all credits, the third is refused
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA1, 1'b0, 1'b1);
      check_handshake(HS_ACK);
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA0, 1'b0, 1'b1);
      check_handshake(HS_ACK);
      send_token(PID_OUT, {`SIE_ENDP_BULK, DEV_ADDR}, 1'b0);
      make_payload(`SIE_MAX_PACKET);
      send_data(PID_DATA1, 1'b0, 1'b0);
      check_handshake(HS_NAK);
      assert (exp_q.size() == 2 * `SIE_MAX_PACKET)
         else mismatch("expected byte count", 2 * `SIE_MAX_PACKET, exp_q.size());
      @(posedge clk_i);
      out_ready_i <= 1'b1;
      wait_drain();
      finish_test("STALL, NAK and credit exhaustion");

      repeat (4) @(posedge clk_i);
      $display("Tests run %0d, tests failed %0d, check failures %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/sie_rx_top.sv */
/*
 * Receive side of the USB serial interface engine
 * Packet receiver, OUT payload FIFO and handshake sender
 */
`timescale 1ns/10ps
`default_nettype none

module sie_rx_top (
   input  logic        clk_i,
   input  logic        rstn,
   input  logic [7:0]  rx_data_i,
   input  logic        rx_byte_valid_i,
   input  logic        rx_active_i,
   input  logic        rx_err_i,
   input  logic [6:0]  addr_i,
   input  logic        stall_i,
   input  logic        out_nak_i,
   input  logic        out_ready_i,
   input  logic        tx_ready_i,
   output logic [7:0]  out_data_o,
   output logic        out_valid_o,
   output logic [7:0]  tx_data_o,
   output logic        tx_valid_o,
   output logic [10:0] frame_o,
   output logic [3:0]  endp_o,
   output logic        setup_o
);

   logic          wr_en;
   logic [7:0]    wr_data;
   logic          commit;
   logic          discard;
   logic          credit_return;
   logic          hs_req;
   sie_pkg::pid_e hs_pid;

   usb_packet_rx i_packet_rx (
      .clk_i           (clk_i),
      .rstn            (rstn),
      .rx_data_i       (rx_data_i),
      .rx_byte_valid_i (rx_byte_valid_i),
      .rx_active_i     (rx_active_i),
      .rx_err_i        (rx_err_i),
      .addr_i          (addr_i),
      .stall_i         (stall_i),
      .out_nak_i       (out_nak_i),
      .credit_return_i (credit_return),
      .wr_en_o         (wr_en),
      .wr_data_o       (wr_data),
      .commit_o        (commit),
      .discard_o       (discard),
      .hs_req_o        (hs_req),
      .hs_pid_o        (hs_pid),
      .frame_o         (frame_o),
      .endp_o          (endp_o),
      .setup_o         (setup_o)
   );

   usb_out_fifo i_out_fifo (
      .clk_i           (clk_i),
      .rstn            (rstn),
      .wr_en_i         (wr_en),
      .wr_data_i       (wr_data),
      .commit_i        (commit),
      .discard_i       (discard),
      .out_ready_i     (out_ready_i),
      .out_data_o      (out_data_o),
      .out_valid_o     (out_valid_o),
      .credit_return_o (credit_return)
   );

   usb_handshake_tx i_handshake_tx (
      .clk_i      (clk_i),
      .rstn       (rstn),
      .hs_req_i   (hs_req),
      .hs_pid_i   (hs_pid),
      .tx_ready_i (tx_ready_i),
      .tx_data_o  (tx_data_o),
      .tx_valid_o (tx_valid_o)
   );

endmodule

`default_nettype wire

/* rtl/usb_handshake_tx.sv */
/*
 * Handshake sender
 * Latches the verdict, waits out the bus turnaround and
 * holds the PID byte until the PHY takes it
 */
`timescale 1ns/10ps
`default_nettype none
`include "sie_settings.svh"

module usb_handshake_tx (
   input  logic          clk_i,
   input  logic          rstn,
   input  logic          hs_req_i,
   input  sie_pkg::pid_e hs_pid_i,
   input  logic          tx_ready_i,
   output logic [7:0]    tx_data_o,
   output logic          tx_valid_o
);

   localparam int CNT_W = $clog2(`SIE_TURNAROUND);

   logic             pend_q;
   logic [CNT_W-1:0] cnt_q;
   sie_pkg::pid_e    pid_q;

   // Request comes one cycle after end of packet, the load cycle costs one more
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         pend_q     <= 1'b0;
         cnt_q      <= '0;
         tx_valid_o <= 1'b0;
      end else if (hs_req_i) begin
         pend_q <= 1'b1;
         cnt_q  <= CNT_W'(`SIE_TURNAROUND - 3);
      end else if (pend_q) begin
         if (cnt_q == '0) begin
            pend_q     <= 1'b0;
            tx_valid_o <= 1'b1;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end else if (tx_ready_i) begin
         tx_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (hs_req_i) begin
         pid_q <= hs_pid_i;
      end
   end

   assign tx_data_o = {~pid_q, pid_q};

   // Packet receiver never overlaps two handshakes
   no_req_while_busy: assert property (@(posedge clk_i) disable iff (!rstn)
      hs_req_i |-> !(pend_q || tx_valid_o));

endmodule

`default_nettype wire

/* rtl/usb_out_fifo.sv */
/*
 * OUT payload FIFO
 * Tentative write pointer, commit and discard,
 * registered valid/ready output and credit return
 */
`timescale 1ns/10ps
`default_nettype none
`include "sie_settings.svh"

module usb_out_fifo (
   input  logic       clk_i,
   input  logic       rstn,
   input  logic       wr_en_i,
   input  logic [7:0] wr_data_i,
   input  logic       commit_i,
   input  logic       discard_i,
   input  logic       out_ready_i,
   output logic [7:0] out_data_o,
   output logic       out_valid_o,
   output logic       credit_return_o
);

   localparam int AW = $clog2(`SIE_FIFO_DEPTH);
   localparam int PW = AW + 1;

   logic [7:0]    mem_q [`SIE_FIFO_DEPTH];
   logic [PW-1:0] wr_tent_q;
   logic [PW-1:0] wr_comm_q;
   logic [PW-1:0] rd_q;
   logic          full;
   logic          load;

   assign full = ((wr_tent_q - rd_q) == PW'(`SIE_FIFO_DEPTH));
   // Only committed entries move to the output register
   assign load = (rd_q != wr_comm_q) && (!out_valid_o || out_ready_i);
   assign credit_return_o = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem_q[wr_tent_q[AW-1:0]] <= wr_data_i;
      end
      if (load) begin
         out_data_o <= mem_q[rd_q[AW-1:0]];
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         wr_tent_q   <= '0;
         wr_comm_q   <= '0;
         rd_q        <= '0;
         out_valid_o <= 1'b0;
      end else begin
         if (discard_i) begin
            wr_tent_q <= wr_comm_q;
         end else if (wr_en_i) begin
            wr_tent_q <= wr_tent_q + 1'b1;
         end
         if (commit_i) begin
            wr_comm_q <= wr_tent_q;
         end
         if (load) begin
            rd_q        <= rd_q + 1'b1;
            out_valid_o <= 1'b1;
         end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
         end
      end
   end

   // Receiver credits must keep writes away from a full FIFO
   no_write_when_full: assert property (@(posedge clk_i) disable iff (!rstn)
      wr_en_i |-> !full);

endmodule

`default_nettype wire

/* rtl/usb_packet_rx.sv */
/*
 * Byte level USB packet receiver
 *  - PID check and decode
 *  - Token CRC5 check, frame number and endpoint capture
 *  - DATA0/DATA1 reception with CRC16, toggles and FIFO credits
 *  - Handshake verdict for the handshake sender
 */
`timescale 1ns/10ps
`default_nettype none
`include "sie_settings.svh"

module usb_packet_rx (
   input  logic          clk_i,
   input  logic          rstn,
   input  logic [7:0]    rx_data_i,
   input  logic          rx_byte_valid_i,
   input  logic          rx_active_i,
   input  logic          rx_err_i,
   input  logic [6:0]    addr_i,
   input  logic          stall_i,
   input  logic          out_nak_i,
   input  logic          credit_return_i,
   output logic          wr_en_o,
   output logic [7:0]    wr_data_o,
   output logic          commit_o,
   output logic          discard_o,
   output logic          hs_req_o,
   output sie_pkg::pid_e hs_pid_o,
   output logic [10:0]   frame_o,
   output logic [3:0]    endp_o,
   output logic          setup_o
);

   localparam int CRED_W = $clog2(`SIE_FIFO_DEPTH + 1);
   localparam int CNT_W  = $clog2(`SIE_MAX_PACKET + 3);
   localparam int PKT_W  = $clog2(`SIE_MAX_PACKET + 1);

   localparam logic [2:0] ST_IDLE    = 3'd0,
                          ST_TOK1    = 3'd1,
                          ST_TOK2    = 3'd2,
                          ST_TOK_CHK = 3'd3,
                          ST_DATA    = 3'd4,
                          ST_IGNORE  = 3'd5;

   logic [2:0]        state_q;
   logic              rx_active_q;
   logic              eop;
   logic              pid_byte;
   logic              pid_ok;
   sie_pkg::pid_e     pid_q;
   logic [7:0]        tok_lo_q;
   logic [7:0]        tok_hi_q;
   sie_pkg::token_u   token;
   logic              tok_crc_ok;
   logic              tok_match_q;
   logic              tog_ctrl_q;
   logic              tog_bulk_q;
   logic              tog_cur;
   logic              endp_known;
   logic [7:0]        dly1_q;
   logic [7:0]        dly2_q;
   logic [CNT_W-1:0]  byte_cnt_q;
   logic              long_q;
   logic              store_q;
   logic [PKT_W-1:0]  pkt_cnt_q;
   logic [CRED_W-1:0] credit_q;
   logic              crc16_ok;
   logic              data_good;
   sie_pkg::pid_e     verdict;

   assign eop        = rx_active_q & ~rx_active_i;
   assign pid_byte   = rx_byte_valid_i & ~rx_err_i & (state_q == ST_IDLE);
   assign pid_ok     = (rx_data_i[7:4] == ~rx_data_i[3:0]);
   assign token      = {tok_hi_q[2:0], tok_lo_q};
   assign tok_crc_ok = sie_pkg::crc5_ok(token.frame, tok_hi_q[7:3]);
   assign tog_cur    = (endp_o == `SIE_ENDP_CTRL) ? tog_ctrl_q : tog_bulk_q;
   assign endp_known = (endp_o == `SIE_ENDP_CTRL) || (endp_o == `SIE_ENDP_BULK);
   // At least the two CRC bytes, no babble
   assign data_good  = crc16_ok & ~long_q & (byte_cnt_q >= CNT_W'(2));

   always_comb begin
      if (stall_i) begin
         verdict = sie_pkg::PID_STALL;
      end else if (out_nak_i || !store_q) begin
         verdict = sie_pkg::PID_NAK;
      end else begin
         verdict = sie_pkg::PID_ACK;
      end
   end

   usb_crc16 i_crc16 (
      .clk_i         (clk_i),
      .rstn          (rstn),
      .init_i        (pid_byte),
      .byte_valid_i  (rx_byte_valid_i & ~rx_err_i & (state_q == ST_DATA)),
      .data_i        (rx_data_i),
      .residual_ok_o (crc16_ok)
   );

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q     <= ST_IDLE;
         rx_active_q <= 1'b0;
         pid_q       <= sie_pkg::PID_RESERVED;
         tok_match_q <= 1'b0;
         frame_o     <= 11'd0;
         endp_o      <= `SIE_ENDP_CTRL;
         setup_o     <= 1'b0;
         tog_ctrl_q  <= 1'b0;
         tog_bulk_q  <= 1'b0;
         byte_cnt_q  <= '0;
         long_q      <= 1'b0;
         store_q     <= 1'b0;
         wr_en_o     <= 1'b0;
         commit_o    <= 1'b0;
         discard_o   <= 1'b0;
         hs_req_o    <= 1'b0;
      end else begin
         rx_active_q <= rx_active_i;
         wr_en_o     <= 1'b0;
         commit_o    <= 1'b0;
         discard_o   <= 1'b0;
         hs_req_o    <= 1'b0;
         if (eop) begin
            state_q <= ST_IDLE;
            case (state_q)
               ST_TOK_CHK: begin
                  if (tok_crc_ok && pid_q == sie_pkg::PID_SOF) begin
                     frame_o <= token.frame;
                  end else if (tok_crc_ok && token.dev.addr == addr_i) begin
                     tok_match_q <= (pid_q == sie_pkg::PID_OUT) || (pid_q == sie_pkg::PID_SETUP);
                     if ((pid_q == sie_pkg::PID_OUT) || (pid_q == sie_pkg::PID_SETUP)) begin
                        endp_o  <= token.dev.endp;
                        setup_o <= (pid_q == sie_pkg::PID_SETUP);
                     end
                     // Setup stage always starts with DATA0
                     if (pid_q == sie_pkg::PID_SETUP) begin
                        tog_ctrl_q <= 1'b0;
                     end
                  end else if (tok_crc_ok) begin
                     tok_match_q <= 1'b0;
                  end
               end
               ST_DATA: begin
                  hs_req_o <= data_good;
                  if (data_good && verdict == sie_pkg::PID_ACK && endp_known &&
                      tog_cur == pid_q[3]) begin
                     commit_o <= 1'b1;
                     if (endp_o == `SIE_ENDP_CTRL) begin
                        tog_ctrl_q <= ~tog_ctrl_q;
                     end else begin
                        tog_bulk_q <= ~tog_bulk_q;
                     end
                  end else begin
                     // Repeated packet is still ACKed but its bytes are dropped
                     discard_o <= store_q;
                  end
               end
               default: begin
               end
            endcase
         end else if (rx_err_i && rx_active_i) begin
            state_q   <= ST_IGNORE;
            discard_o <= store_q && (state_q == ST_DATA);
         end else if (rx_byte_valid_i) begin
            case (state_q)
               ST_IDLE: begin
                  pid_q      <= sie_pkg::pid_e'(rx_data_i[3:0]);
                  byte_cnt_q <= '0;
                  long_q     <= 1'b0;
                  store_q    <= (credit_q >= CRED_W'(`SIE_MAX_PACKET));
                  if (!pid_ok) begin
                     state_q <= ST_IGNORE;
                  end else begin
                     case (rx_data_i[3:0])
                        sie_pkg::PID_OUT, sie_pkg::PID_IN,
                        sie_pkg::PID_SOF, sie_pkg::PID_SETUP: state_q <= ST_TOK1;
                        sie_pkg::PID_DATA0, sie_pkg::PID_DATA1: begin
                           state_q <= tok_match_q ? ST_DATA : ST_IGNORE;
                        end
                        default: state_q <= ST_IGNORE;
                     endcase
                  end
               end
               ST_TOK1: state_q <= ST_TOK2;
               ST_TOK2: state_q <= ST_TOK_CHK;
               ST_DATA: begin
                  if (byte_cnt_q == CNT_W'(`SIE_MAX_PACKET + 2)) begin
                     long_q <= 1'b1;
                  end else begin
                     byte_cnt_q <= byte_cnt_q + 1'b1;
                     // Two bytes held back, the last two are the CRC
                     wr_en_o    <= store_q && (byte_cnt_q >= CNT_W'(2));
                  end
               end
               default: state_q <= ST_IGNORE;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_byte_valid_i && state_q == ST_TOK1) begin
         tok_lo_q <= rx_data_i;
      end
      if (rx_byte_valid_i && state_q == ST_TOK2) begin
         tok_hi_q <= rx_data_i;
      end
      if (rx_byte_valid_i && state_q == ST_DATA) begin
         dly1_q    <= rx_data_i;
         dly2_q    <= dly1_q;
         wr_data_o <= dly2_q;
      end
      if (eop && state_q == ST_DATA) begin
         hs_pid_o <= verdict;
      end
   end

   // Credits mirror free FIFO space, a discard gives back what the packet took
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         credit_q  <= CRED_W'(`SIE_FIFO_DEPTH);
         pkt_cnt_q <= '0;
      end else begin
         credit_q <= credit_q - CRED_W'(wr_en_o) + CRED_W'(credit_return_i) +
                     (discard_o ? CRED_W'(pkt_cnt_q) : '0);
         if (pid_byte) begin
            pkt_cnt_q <= '0;
         end else if (wr_en_o) begin
            pkt_cnt_q <= pkt_cnt_q + 1'b1;
         end
      end
   end

   commit_discard_excl: assert property (@(posedge clk_i) disable iff (!rstn)
      !(commit_o && discard_o));

endmodule

`default_nettype wire

/* rtl/usb_crc16.sv */
/*
 * Bytewise CRC16 accumulator for USB data packets
 * with restart and residual match flag
 */
`timescale 1ns/10ps
`default_nettype none
`include "sie_settings.svh"

module usb_crc16 (
   input  logic       clk_i,
   input  logic       rstn,
   input  logic       init_i,
   input  logic       byte_valid_i,
   input  logic [7:0] data_i,
   output logic       residual_ok_o
);

   localparam logic [15:0] POLY = 16'h8005;

   logic [15:0] crc_q;
   logic [15:0] crc_next;

   // One byte per cycle, bit 0 goes in first
   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (data_i[i] ^ crc_next[15]) begin
            crc_next = {crc_next[14:0], 1'b0} ^ POLY;
         end else begin
            crc_next = {crc_next[14:0], 1'b0};
         end
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         crc_q <= 16'hFFFF;
      end else if (init_i) begin
         crc_q <= 16'hFFFF;
      end else if (byte_valid_i) begin
         crc_q <= crc_next;
      end
   end

   assign residual_ok_o = (crc_q == `SIE_CRC16_RESIDUAL);

endmodule

`default_nettype wire

/* rtl/sie_pkg.sv */
/*
 * Shared USB receive types
 *  - PID codes
 *  - Token payload with address/endpoint and frame number views
 *  - CRC5 check of a token payload
 */
`default_nettype none

package sie_pkg;

   typedef enum logic [3:0] {
      PID_RESERVED = 4'b0000,
      PID_OUT      = 4'b0001,
      PID_IN       = 4'b1001,
      PID_SOF      = 4'b0101,
      PID_SETUP    = 4'b1101,
      PID_DATA0    = 4'b0011,
      PID_DATA1    = 4'b1011,
      PID_ACK      = 4'b0010,
      PID_NAK      = 4'b1010,
      PID_STALL    = 4'b1110
   } pid_e;

   // Address is sent first, so it sits in the low bits
   typedef union packed {
      struct packed {
         logic [3:0] endp;
         logic [6:0] addr;
      } dev;
      logic [10:0] frame;
   } token_u;

   // Payload bits are folded LSB first, the received CRC arrives bit reversed and inverted
   function automatic logic crc5_ok(input logic [10:0] data, input logic [4:0] crc_rx);
      logic [4:0] crc;
      logic [4:0] crc_ref;
      crc = 5'b11111;
      for (int i = 0; i < 11; i++) begin
         if (data[i] ^ crc[4]) begin
            crc = {crc[3:0], 1'b0} ^ 5'b00101;
         end else begin
            crc = {crc[3:0], 1'b0};
         end
      end
      for (int i = 0; i < 5; i++) begin
         crc_ref[i] = ~crc_rx[4-i];
      end
      return crc == crc_ref;
   endfunction

endpackage

`default_nettype wire

/* rtl/sie_settings.svh */
/*
 * Size, endpoint, timing and CRC constants of the USB receive engine
 */
`ifndef SIE_SETTINGS_SVH
`define SIE_SETTINGS_SVH

// Largest data payload accepted in one packet
`define SIE_MAX_PACKET 8
// Payload FIFO entries, also the initial credit count
`define SIE_FIFO_DEPTH 16
// Cycles from end of packet to the handshake byte
`define SIE_TURNAROUND 8

`define SIE_ENDP_CTRL 4'd0
`define SIE_ENDP_BULK 4'd1

// CRC16 remainder left after the two CRC bytes have been folded in
`define SIE_CRC16_RESIDUAL 16'h800D

`endif
